// File: source/mem_defines.svh
/*
 * memory subsystem parameters: bus widths, tracker depth and vector constants
 */
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// bus widths
`define MEM_ADDR_W      32  // byte address
`define MEM_DATA_W      64  // memory bus, equal to the vector port width
`define MEM_SCALAR_W    32  // scalar data and instruction words

// outstanding memory requests across all sources
`define MEM_TRACK_DEPTH 32

// vector unit
`define VEC_ID_W        3
`define VCSR_VLENB      16  // vector register length in bytes

`endif

// File: source/mem_bus_pkg.sv
/*
 * memory path types: request and response bundles, request source
 */
`default_nettype none

`include "mem_defines.svh"

package mem_bus_pkg;

    // 32-bit lanes on the wide bus
    localparam int unsigned SCALAR_LANES    = `MEM_DATA_W / `MEM_SCALAR_W;
    localparam int unsigned SCALAR_LANE_W   = $clog2(SCALAR_LANES);
    localparam int unsigned SCALAR_LANE_LSB = $clog2(`MEM_SCALAR_W / 8);  // byte offset bits

    typedef struct packed {
        logic [`MEM_ADDR_W-1:0]   addr;
        logic                     we;
        logic [`MEM_DATA_W/8-1:0] be;
        logic [`MEM_DATA_W-1:0]   wdata;
    } mem_req_t;

    typedef struct packed {
        logic [`MEM_ADDR_W-1:0]     addr;
        logic                       we;
        logic [`MEM_SCALAR_W/8-1:0] be;
        logic [`MEM_SCALAR_W-1:0]   wdata;
    } scalar_req_t;

    typedef struct packed {
        mem_req_t             req;
        logic [`VEC_ID_W-1:0] id;
    } vec_req_t;

    typedef struct packed {
        logic [`VEC_ID_W-1:0]   id;
        logic [`MEM_DATA_W-1:0] rdata;
        logic                   err;
    } vec_resp_t;

    typedef enum logic {
        SRC_INSTR = 1'b0,
        SRC_DATA  = 1'b1
    } req_src_e;

endpackage

`default_nettype wire

// File: source/vcsr_pkg.sv
/*
 * vector CSR types: addresses, access request, register state and unit config
 */
`default_nettype none

package vcsr_pkg;

    typedef enum logic [11:0] {
        VSTART = 12'h008,
        VXSAT  = 12'h009,
        VXRM   = 12'h00A,
        VCSR   = 12'h00F,
        VL     = 12'hC20,
        VTYPE  = 12'hC21,
        VLENB  = 12'hC22
    } vcsr_addr_e;

    typedef struct packed {
        logic [11:0] addr;  // raw address, may hit none of the above
        logic        we;
        logic [31:0] wdata;
    } vcsr_req_t;

    typedef struct packed {
        logic [31:0] vstart;
        logic [1:0]  vxrm;
        logic        vxsat;
    } vcsr_state_t;

    typedef struct packed {
        logic [31:0] vl;
        logic [31:0] vtype;
    } vec_cfg_t;

endpackage

`default_nettype wire

// File: source/vcsr_regs.sv
/*
 * vector CSR block: holds vstart, vxsat and vxrm, vcsr alias,
 * read-only mirrors of vl and vtype plus constant vlenb
 */
`default_nettype none
`timescale 1ns/100ps

`include "mem_defines.svh"

module vcsr_regs (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  vcsr_pkg::vcsr_req_t   csr_req_i,
    input  vcsr_pkg::vec_cfg_t    vec_cfg_i,
    output logic [31:0]           csr_rdata_o,
    output vcsr_pkg::vcsr_state_t csr_state_o
);
    import vcsr_pkg::*;

    vcsr_state_t state_q, state_d;

    // write decode, vl/vtype/vlenb ignore writes
    always_comb begin
        state_d = state_q;
        if (csr_req_i.we) begin
            case (csr_req_i.addr)
                VSTART: state_d.vstart = csr_req_i.wdata;
                VXSAT:  state_d.vxsat  = csr_req_i.wdata[0];
                VXRM:   state_d.vxrm   = csr_req_i.wdata[1:0];
                VCSR: begin
                    state_d.vxrm  = csr_req_i.wdata[2:1];
                    state_d.vxsat = csr_req_i.wdata[0];
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= '0;
        end else begin
            state_q <= state_d;
        end
    end

    // read mux
    always_comb begin
        case (csr_req_i.addr)
            VSTART:  csr_rdata_o = state_q.vstart;
            VXSAT:   csr_rdata_o = {31'b0, state_q.vxsat};
            VXRM:    csr_rdata_o = {30'b0, state_q.vxrm};
            VCSR:    csr_rdata_o = {29'b0, state_q.vxrm, state_q.vxsat};
            VL:      csr_rdata_o = vec_cfg_i.vl;
            VTYPE:   csr_rdata_o = vec_cfg_i.vtype;
            VLENB:   csr_rdata_o = 32'(`VCSR_VLENB);
            default: csr_rdata_o = '0;
        endcase
    end

    assign csr_state_o = state_q;

endmodule

`default_nettype wire

// File: source/data_port_arbiter.sv
/*
 * data arbiter: merges the scalar load/store port and the wide vector port,
 * vector first, and returns each response to the side that issued it
 */
`default_nettype none
`timescale 1ns/100ps

`include "mem_defines.svh"

module data_port_arbiter (
    input  logic                     clk_i,
    input  logic                     rst_ni,

    // scalar port
    input  logic                     s_req_i,
    input  mem_bus_pkg::scalar_req_t s_req_data_i,
    output logic                     s_gnt_o,
    output logic                     s_rvalid_o,
    output logic                     s_err_o,
    output logic [`MEM_SCALAR_W-1:0] s_rdata_o,

    // vector port
    input  logic                     v_req_i,
    input  mem_bus_pkg::vec_req_t    v_req_data_i,
    output logic                     v_gnt_o,
    output logic                     v_rvalid_o,
    output mem_bus_pkg::vec_resp_t   v_resp_o,

    input  logic                     pending_load_i,
    input  logic                     pending_store_i,

    // toward the memory arbiter
    output logic                     d_req_o,
    output mem_bus_pkg::mem_req_t    d_req_data_o,
    input  logic                     d_gnt_i,
    input  logic                     d_rvalid_i,
    input  logic                     d_err_i,
    input  logic [`MEM_DATA_W-1:0]   d_rdata_i
);
    import mem_bus_pkg::*;

    localparam int unsigned BE_W        = `MEM_DATA_W / 8;
    localparam int unsigned SCALAR_BE_W = `MEM_SCALAR_W / 8;

    logic                     s_waiting_q, v_waiting_q;
    logic [SCALAR_LANE_W-1:0] s_lane_q;  // read lane of the scalar access in flight
    logic [`VEC_ID_W-1:0]     v_id_q;

    logic                     data_busy;
    logic                     s_hold;
    logic                     s_ok, v_ok;
    logic [SCALAR_LANE_W-1:0] s_lane;

    ////////////////////////////////////////////////////////////
    // arbitration

    // the slot frees up in the cycle its response returns
    assign data_busy = (s_waiting_q | v_waiting_q) & ~d_rvalid_i;

    // scalar stays off the bus around vector traffic
    assign s_hold = v_req_i | pending_store_i | (pending_load_i & s_req_data_i.we);

    assign v_ok = v_req_i & ~data_busy;
    assign s_ok = s_req_i & ~s_hold & ~data_busy;

    assign d_req_o = v_ok | s_ok;
    assign v_gnt_o = d_gnt_i & v_ok;
    assign s_gnt_o = d_gnt_i & s_ok;

    ////////////////////////////////////////////////////////////
    // width fitting

    assign s_lane = s_req_data_i.addr[SCALAR_LANE_LSB +: SCALAR_LANE_W];

    always_comb begin
        d_req_data_o.addr  = s_req_data_i.addr;
        d_req_data_o.we    = s_req_data_i.we;
        d_req_data_o.be    = BE_W'(s_req_data_i.be) << (s_lane * SCALAR_BE_W);
        d_req_data_o.wdata = {SCALAR_LANES{s_req_data_i.wdata}};  // word in every lane
        if (v_req_i) begin
            d_req_data_o = v_req_data_i.req;
        end
    end

    ////////////////////////////////////////////////////////////
    // response return

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            s_waiting_q <= 1'b0;
            v_waiting_q <= 1'b0;
        end else begin
            if (s_gnt_o) begin
                s_waiting_q <= 1'b1;
            end else if (s_rvalid_o) begin
                s_waiting_q <= 1'b0;
            end
            if (v_gnt_o) begin
                v_waiting_q <= 1'b1;
            end else if (v_rvalid_o) begin
                v_waiting_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (s_gnt_o) begin
            s_lane_q <= s_lane;
        end
        if (v_gnt_o) begin
            v_id_q <= v_req_data_i.id;
        end
    end

    assign s_rvalid_o = s_waiting_q & d_rvalid_i;
    assign v_rvalid_o = v_waiting_q & d_rvalid_i;

    assign s_err_o   = s_rvalid_o & d_err_i;
    assign s_rdata_o = d_rdata_i[s_lane_q * `MEM_SCALAR_W +: `MEM_SCALAR_W];

    assign v_resp_o.id    = v_id_q;
    assign v_resp_o.rdata = d_rdata_i;
    assign v_resp_o.err   = v_rvalid_o & d_err_i;

endmodule

`default_nettype wire

// File: source/mem_port_arbiter.sv
/*
 * memory arbiter: merges instruction fetches and data accesses onto one bus
 * and routes the in-order responses back through a request tracker
 */
`default_nettype none
`timescale 1ns/100ps

`include "mem_defines.svh"

module mem_port_arbiter (
    input  logic                     clk_i,
    input  logic                     rst_ni,

    // instruction port
    input  logic                     i_req_i,
    input  logic [`MEM_ADDR_W-1:0]   i_addr_i,
    output logic                     i_gnt_o,
    output logic                     i_rvalid_o,
    output logic                     i_err_o,
    output logic [`MEM_SCALAR_W-1:0] i_rdata_o,

    // merged data side
    input  logic                     d_req_i,
    input  mem_bus_pkg::mem_req_t    d_req_data_i,
    output logic                     d_gnt_o,
    output logic                     d_rvalid_o,
    output logic                     d_err_o,
    output logic [`MEM_DATA_W-1:0]   d_rdata_o,

    // memory bus
    output logic                     mem_req_o,
    output mem_bus_pkg::mem_req_t    mem_req_data_o,
    input  logic                     mem_rvalid_i,
    input  logic                     mem_err_i,
    input  logic [`MEM_DATA_W-1:0]   mem_rdata_i
);
    import mem_bus_pkg::*;

    localparam int unsigned DEPTH = `MEM_TRACK_DEPTH;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);
    localparam int unsigned IDX_W = $clog2(DEPTH);

    typedef struct packed {
        req_src_e                 src;
        logic [SCALAR_LANE_W-1:0] lane;  // fetch word lane
    } track_entry_t;

    track_entry_t             track_q [DEPTH];
    track_entry_t             new_entry;
    track_entry_t             head;
    logic [CNT_W-1:0]         count_q;
    logic [IDX_W-1:0]         push_idx;
    logic                     can_issue;
    logic                     push;

    ////////////////////////////////////////////////////////////
    // request merge

    // a response in the same cycle frees one slot
    assign can_issue = (count_q != CNT_W'(DEPTH)) | mem_rvalid_i;

    assign d_gnt_o   = d_req_i & can_issue;
    assign i_gnt_o   = i_req_i & ~d_req_i & can_issue;  // data goes first
    assign push      = d_gnt_o | i_gnt_o;
    assign mem_req_o = push;

    always_comb begin
        mem_req_data_o.addr  = i_addr_i;
        mem_req_data_o.we    = 1'b0;
        mem_req_data_o.be    = '1;
        mem_req_data_o.wdata = '0;
        if (d_req_i) begin
            mem_req_data_o = d_req_data_i;
        end
    end

    ////////////////////////////////////////////////////////////
    // in-order tracker

    assign new_entry.src  = d_req_i ? SRC_DATA : SRC_INSTR;
    assign new_entry.lane = i_addr_i[SCALAR_LANE_LSB +: SCALAR_LANE_W];

    // wraps to the last slot when full and popping
    assign push_idx = count_q[IDX_W-1:0] - IDX_W'(mem_rvalid_i);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            count_q <= '0;
        end else begin
            count_q <= count_q + CNT_W'(push) - CNT_W'(mem_rvalid_i);
        end
    end

    always_ff @(posedge clk_i) begin
        if (mem_rvalid_i) begin
            for (int i = 0; i < DEPTH - 1; i++) begin
                track_q[i] <= track_q[i+1];
            end
        end
        if (push) begin
            track_q[push_idx] <= new_entry;  // overrides the shift for that slot
        end
    end

    ////////////////////////////////////////////////////////////
    // response routing

    assign head = track_q[0];

    assign i_rvalid_o = mem_rvalid_i & (head.src == SRC_INSTR);
    assign d_rvalid_o = mem_rvalid_i & (head.src == SRC_DATA);

    assign i_err_o = i_rvalid_o & mem_err_i;
    assign d_err_o = d_rvalid_o & mem_err_i;

    assign i_rdata_o = mem_rdata_i[head.lane * `MEM_SCALAR_W +: `MEM_SCALAR_W];
    assign d_rdata_o = mem_rdata_i;

endmodule

`default_nettype wire

// File: source/mem_subsys_top.sv
/*
 * memory subsystem top: data arbiter, memory arbiter and vector CSR block
 */
`default_nettype none
`timescale 1ns/100ps

`include "mem_defines.svh"

module mem_subsys_top (
    input  logic                     clk_i,
    input  logic                     rst_ni,

    // instruction fetch
    input  logic                     instr_req_i,
    input  logic [`MEM_ADDR_W-1:0]   instr_addr_i,
    output logic                     instr_gnt_o,
    output logic                     instr_rvalid_o,
    output logic                     instr_err_o,
    output logic [`MEM_SCALAR_W-1:0] instr_rdata_o,

    // scalar load/store
    input  logic                     sdata_req_i,
    input  mem_bus_pkg::scalar_req_t sdata_req_data_i,
    output logic                     sdata_gnt_o,
    output logic                     sdata_rvalid_o,
    output logic                     sdata_err_o,
    output logic [`MEM_SCALAR_W-1:0] sdata_rdata_o,

    // vector load/store
    input  logic                     vdata_req_i,
    input  mem_bus_pkg::vec_req_t    vdata_req_data_i,
    output logic                     vdata_gnt_o,
    output logic                     vdata_rvalid_o,
    output mem_bus_pkg::vec_resp_t   vdata_resp_o,
    input  logic                     pending_load_i,
    input  logic                     pending_store_i,

    // vector CSRs
    input  vcsr_pkg::vcsr_req_t      csr_req_i,
    input  vcsr_pkg::vec_cfg_t       vec_cfg_i,
    output logic [31:0]              csr_rdata_o,
    output vcsr_pkg::vcsr_state_t    csr_state_o,

    // memory bus
    output logic                     mem_req_o,
    output mem_bus_pkg::mem_req_t    mem_req_data_o,
    input  logic                     mem_rvalid_i,
    input  logic                     mem_err_i,
    input  logic [`MEM_DATA_W-1:0]   mem_rdata_i
);
    import mem_bus_pkg::*;

    // merged data path between the two arbiters
    logic                   d_req;
    mem_req_t               d_req_data;
    logic                   d_gnt;
    logic                   d_rvalid;
    logic                   d_err;
    logic [`MEM_DATA_W-1:0] d_rdata;

    data_port_arbiter data_port_arbiter_i (
        .clk_i           ( clk_i            ),
        .rst_ni          ( rst_ni           ),
        .s_req_i         ( sdata_req_i      ),
        .s_req_data_i    ( sdata_req_data_i ),
        .s_gnt_o         ( sdata_gnt_o      ),
        .s_rvalid_o      ( sdata_rvalid_o   ),
        .s_err_o         ( sdata_err_o      ),
        .s_rdata_o       ( sdata_rdata_o    ),
        .v_req_i         ( vdata_req_i      ),
        .v_req_data_i    ( vdata_req_data_i ),
        .v_gnt_o         ( vdata_gnt_o      ),
        .v_rvalid_o      ( vdata_rvalid_o   ),
        .v_resp_o        ( vdata_resp_o     ),
        .pending_load_i  ( pending_load_i   ),
        .pending_store_i ( pending_store_i  ),
        .d_req_o         ( d_req            ),
        .d_req_data_o    ( d_req_data       ),
        .d_gnt_i         ( d_gnt            ),
        .d_rvalid_i      ( d_rvalid         ),
        .d_err_i         ( d_err            ),
        .d_rdata_i       ( d_rdata          )
    );

    mem_port_arbiter mem_port_arbiter_i (
        .clk_i          ( clk_i          ),
        .rst_ni         ( rst_ni         ),
        .i_req_i        ( instr_req_i    ),
        .i_addr_i       ( instr_addr_i   ),
        .i_gnt_o        ( instr_gnt_o    ),
        .i_rvalid_o     ( instr_rvalid_o ),
        .i_err_o        ( instr_err_o    ),
        .i_rdata_o      ( instr_rdata_o  ),
        .d_req_i        ( d_req          ),
        .d_req_data_i   ( d_req_data     ),
        .d_gnt_o        ( d_gnt          ),
        .d_rvalid_o     ( d_rvalid       ),
        .d_err_o        ( d_err          ),
        .d_rdata_o      ( d_rdata        ),
        .mem_req_o      ( mem_req_o      ),
        .mem_req_data_o ( mem_req_data_o ),
        .mem_rvalid_i   ( mem_rvalid_i   ),
        .mem_err_i      ( mem_err_i      ),
        .mem_rdata_i    ( mem_rdata_i    )
    );

    vcsr_regs vcsr_regs_i (
        .clk_i       ( clk_i       ),
        .rst_ni      ( rst_ni      ),
        .csr_req_i   ( csr_req_i   ),
        .vec_cfg_i   ( vec_cfg_i   ),
        .csr_rdata_o ( csr_rdata_o ),
        .csr_state_o ( csr_state_o )
    );

endmodule

`default_nettype wire

// File: sim/tb_tasks.svh
/*
 * checks, timeout waits and directed tests of the memory subsystem
 */
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

localparam int TIMEOUT = 200;  // cycles per wait
localparam int W_SGNT = 0, W_SRV = 1, W_VGNT = 2, W_VRV = 3, W_IGNT = 4, W_IRV = 5;

function automatic logic [31:0] pattern(input logic [31:0] a);
    return {a[31:2], 2'b00} ^ PATTERN_KEY;
endfunction

// addresses in this page answer with an error
function automatic logic error_addr(input logic [31:0] a);
    return a[31:12] == 20'h0000f;
endfunction

task automatic check(input logic [63:0] act, input logic [63:0] exp, input string msg);
    if (act !== exp) begin
        $display("FAIL %0t: %s, got %h expected %h", $time, msg, act, exp);
        $display("sim failed");
        $fatal(1);
    end
endtask

function automatic logic strobe(input int sel);
    case (sel)
        W_SGNT:  return sdata_gnt_o;
        W_SRV:   return sdata_rvalid_o;
        W_VGNT:  return vdata_gnt_o;
        W_VRV:   return vdata_rvalid_o;
        W_IGNT:  return instr_gnt_o;
        default: return instr_rvalid_o;
    endcase
endfunction

// returns at the falling edge where the strobe is seen high
task automatic wait_for(input int sel, input string what);
    for (int n = 0; n < TIMEOUT; n++) begin
        @(negedge clk_i);
        if (strobe(sel)) return;
    end
    $display("timeout: %s never happened", what);
    $display("sim failed");
    $fatal(1);
endtask

task automatic scalar_access(input logic [31:0] addr, input logic we, input logic [3:0] be,
                             input logic [31:0] wdata, input logic [31:0] exp, input bit bus);
    @(posedge clk_i);
    sdata_req_i <= 1'b1;
    sdata_req_data_i <= '{addr: addr, we: we, be: be, wdata: wdata};
    wait_for(W_SGNT, "scalar grant");
    if (bus) begin
        check(64'(mem_req_data_o.be), addr[2] ? {be, 4'h0} : {4'h0, be}, "byte enable lane");
        check(mem_req_data_o.wdata, {wdata, wdata}, "write word lanes");
    end
    @(posedge clk_i);
    sdata_req_i <= 1'b0;
    wait_for(W_SRV, "scalar response");
    check(64'(sdata_err_o), 64'(error_addr(addr)), "scalar error");
    if (!we) check(64'(sdata_rdata_o), 64'(exp), "scalar read data");
endtask

task automatic vector_read(input logic [31:0] addr, input logic [2:0] id);
    @(posedge clk_i);
    vdata_req_i <= 1'b1;
    vdata_req_data_i <= '{req: '{addr: addr, we: 1'b0, be: '1, wdata: '0}, id: id};
    wait_for(W_VGNT, "vector grant");
    @(posedge clk_i);
    vdata_req_i <= 1'b0;
    wait_for(W_VRV, "vector response");
    check(64'(vdata_resp_o.id), 64'(id), "vector id");
    check(64'(vdata_resp_o.err), 64'(error_addr(addr)), "vector error");
    check(vdata_resp_o.rdata, {pattern(addr + 4), pattern(addr)}, "vector read data");
endtask

task automatic csr_write(input logic [11:0] addr, input logic [31:0] data);
    @(posedge clk_i);
    csr_req_i <= '{addr: addr, we: 1'b1, wdata: data};
    @(posedge clk_i);
    csr_req_i.we <= 1'b0;
endtask

task automatic csr_read(input logic [11:0] addr, input logic [31:0] exp);
    @(posedge clk_i);
    csr_req_i <= '{addr: addr, we: 1'b0, wdata: '0};
    @(negedge clk_i);
    check(64'(csr_rdata_o), 64'(exp), "csr read data");
endtask

task automatic reset_defaults();
    @(negedge clk_i);
    check(64'({mem_req_o, instr_gnt_o, sdata_gnt_o, vdata_gnt_o}), 0, "grants after reset");
    check(64'({instr_rvalid_o, sdata_rvalid_o, vdata_rvalid_o}), 0, "rvalids after reset");
    check(64'(csr_state_o), 0, "csr state after reset");
    csr_read(VLENB, 16);
    csr_read(12'h123, 0);  // unknown address
endtask

task automatic csr_access_rules();
    csr_write(VSTART, 32'h0000_0013);
    csr_write(VXSAT, 32'h1);
    csr_write(VXRM, 32'h2);
    csr_read(VSTART, 32'h13);
    csr_read(VXSAT, 1);
    csr_read(VXRM, 2);
    csr_write(VCSR, 32'h3);  // vxrm 1, vxsat 1
    csr_read(VXRM, 1);
    csr_read(VCSR, 3);
    csr_write(VL, 32'h55);
    csr_write(VTYPE, 32'h66);
    csr_read(VL, 8);
    csr_read(VTYPE, 32'hd1);
    @(posedge clk_i);
    vec_cfg_i <= '{vl: 32'd3, vtype: 32'h0000_0042};
    csr_read(VL, 3);
    csr_read(VTYPE, 32'h42);
    check(64'(csr_state_o), {32'h13, 2'd1, 1'b1}, "csr state");
endtask

task automatic scalar_lanes();
    scalar_access(32'h100, 1'b1, 4'hf, 32'hdead_beef, 0, 1);
    scalar_access(32'h104, 1'b1, 4'h3, 32'h1234_5678, 0, 1);
    scalar_access(32'h100, 1'b0, 4'hf, 0, 32'hdead_beef, 1);
    scalar_access(32'h104, 1'b0, 4'hf, 0,
                  (pattern(32'h104) & 32'hffff_0000) | 32'h0000_5678, 0);
    scalar_access(32'h20c, 1'b0, 4'hf, 0, pattern(32'h20c), 0);
    scalar_access(32'hf004, 1'b0, 4'hf, 0, pattern(32'hf004), 0);
endtask

// scalar request that must stay ungranted until the pending level drops
task automatic held_then_granted(input logic we, input bit store);
    @(posedge clk_i);
    sdata_req_i <= 1'b1;
    sdata_req_data_i <= '{addr: 32'h300, we: we, be: 4'hf, wdata: 32'h7};
    repeat (4) begin
        @(negedge clk_i);
        check(64'(sdata_gnt_o), 0, "scalar granted while held");
    end
    @(posedge clk_i);
    if (store) pending_store_i <= 1'b0;
    else pending_load_i <= 1'b0;
    wait_for(W_SGNT, "scalar grant after hold");
    @(posedge clk_i);
    sdata_req_i <= 1'b0;
    wait_for(W_SRV, "scalar response after hold");
endtask

task automatic priority_and_hold();
    @(posedge clk_i);
    sdata_req_i <= 1'b1;
    sdata_req_data_i <= '{addr: 32'h400, we: 1'b0, be: 4'hf, wdata: 0};
    vdata_req_i <= 1'b1;
    vdata_req_data_i <= '{req: '{addr: 32'h500, we: 1'b0, be: '1, wdata: '0}, id: 3'd5};
    @(negedge clk_i);
    check(64'({vdata_gnt_o, sdata_gnt_o}), 2'b10, "vector wins over scalar");
    @(posedge clk_i);
    vdata_req_i <= 1'b0;
    wait_for(W_VRV, "vector response");
    check(64'(vdata_resp_o.id), 5, "vector id");
    if (!sdata_gnt_o) begin  // the slot may free up with the vector response
        wait_for(W_SGNT, "scalar grant after vector");
    end
    @(posedge clk_i);
    sdata_req_i <= 1'b0;
    wait_for(W_SRV, "scalar response");
    check(64'(sdata_rdata_o), 64'(pattern(32'h400)), "scalar data after vector");
    @(posedge clk_i);
    pending_store_i <= 1'b1;
    held_then_granted(1'b0, 1);
    @(posedge clk_i);
    pending_load_i <= 1'b1;
    scalar_access(32'h304, 1'b0, 4'hf, 0, pattern(32'h304), 0);
    held_then_granted(1'b1, 0);
endtask

task automatic mixed_traffic();
    logic [31:0] issued[$];
    logic [31:0] a;
    fork
        begin
            for (int i = 0; i < 8; i++) begin
                @(posedge clk_i);
                instr_req_i <= 1'b1;
                // one fetch from the error page
                instr_addr_i <= (i == 5) ? 32'hf00c : 32'h800 + 32'(4 * i * 3);
                wait_for(W_IGNT, "fetch grant");
                issued.push_back(instr_addr_i);
            end
            @(posedge clk_i);
            instr_req_i <= 1'b0;
        end
        begin
            for (int i = 0; i < 8; i++) begin
                wait_for(W_IRV, "fetch response");
                a = issued.pop_front();
                check(64'(instr_err_o), 64'(error_addr(a)), "fetch error");
                check(64'(instr_rdata_o), 64'(pattern(a)), "fetch data in order");
            end
        end
        begin
            scalar_access(32'h604, 1'b0, 4'hf, 0, pattern(32'h604), 0);
            vector_read(32'hf100, 3'd2);
            scalar_access(32'h608, 1'b0, 4'hf, 0, pattern(32'h608), 0);
        end
    join
endtask

`endif

// File: sim/tb_mem_subsys.sv
/*
 * testbench for the memory subsystem with clock, reset and an in-order memory model
 */
`default_nettype none
`timescale 1ns/100ps

`include "mem_defines.svh"

module tb_mem_subsys;
    import mem_bus_pkg::*;
    import vcsr_pkg::*;

    localparam logic [31:0] PATTERN_KEY = 32'hc3a5_0f96;

    logic clk_i = 1'b0;
    logic rst_ni;
    logic instr_req_i, instr_gnt_o, instr_rvalid_o, instr_err_o;
    logic [31:0] instr_addr_i, instr_rdata_o;
    logic sdata_req_i, sdata_gnt_o, sdata_rvalid_o, sdata_err_o;
    scalar_req_t sdata_req_data_i;
    logic [31:0] sdata_rdata_o;
    logic vdata_req_i, vdata_gnt_o, vdata_rvalid_o;
    vec_req_t vdata_req_data_i;
    vec_resp_t vdata_resp_o;
    logic pending_load_i, pending_store_i;
    vcsr_req_t csr_req_i;
    vec_cfg_t vec_cfg_i;
    logic [31:0] csr_rdata_o;
    vcsr_state_t csr_state_o;
    logic mem_req_o;
    logic mem_rvalid_i = 1'b0;
    logic mem_err_i = 1'b0;
    mem_req_t mem_req_data_o;
    logic [63:0] mem_rdata_i = '0;

    int seed = 32'hdf7961d5;
    int unsigned resp_delay;
    logic [64:0] resp_q[$];  // error flag above the read data
    logic [31:0] mem_words [logic [31:0]];

    always #50 clk_i = ~clk_i;

    mem_subsys_top mem_subsys_top_i (.*);

    `include "tb_tasks.svh"

    function automatic logic [31:0] read_word(input logic [31:0] a);
        if (mem_words.exists(a)) return mem_words[a];
        return pattern(a);
    endfunction

    ////////////////////////////////////////////////////////////
    // memory model takes each request and answers in order after a random delay
    always @(posedge clk_i or negedge rst_ni) begin : mem_model
        logic [31:0] base, w;
        logic [63:0] rd;
        if (!rst_ni) begin
            mem_rvalid_i <= 1'b0;
            mem_err_i    <= 1'b0;
            mem_rdata_i  <= '0;
            resp_delay = 0;
        end else begin
            mem_rvalid_i <= 1'b0;
            if (resp_q.size() > 0) begin
                if (resp_delay == 0) begin
                    mem_rvalid_i <= 1'b1;
                    {mem_err_i, mem_rdata_i} <= resp_q.pop_front();
                    resp_delay = $unsigned($random(seed)) % 4;
                end else begin
                    resp_delay--;
                end
            end
            if (mem_req_o) begin
                base = {mem_req_data_o.addr[31:3], 3'b000};
                for (int l = 0; l < 2; l++) begin
                    w = read_word(base + 32'(4 * l));
                    for (int b = 0; b < 4; b++) begin
                        if (mem_req_data_o.we && mem_req_data_o.be[4*l+b])
                            w[8*b +: 8] = mem_req_data_o.wdata[32*l + 8*b +: 8];
                    end
                    if (mem_req_data_o.we) mem_words[base + 32'(4 * l)] = w;
                    rd[32*l +: 32] = w;
                end
                resp_q.push_back({error_addr(mem_req_data_o.addr), rd});
            end
        end
    end

    // bus rules that hold in every cycle
    always @(negedge clk_i) begin
        if (rst_ni) begin
            check(32'(instr_gnt_o & (sdata_gnt_o | vdata_gnt_o)), 0, "fetch granted with data");
            check(32'($countones({instr_rvalid_o, sdata_rvalid_o, vdata_rvalid_o}) > 1), 0,
                  "response on more than one port");
        end
    end

    initial begin
        rst_ni = 1'b0;
        instr_req_i = 1'b0;
        instr_addr_i = '0;
        sdata_req_i = 1'b0;
        sdata_req_data_i = '0;
        vdata_req_i = 1'b0;
        vdata_req_data_i = '0;
        pending_load_i = 1'b0;
        pending_store_i = 1'b0;
        csr_req_i = '0;
        vec_cfg_i = '{vl: 32'd8, vtype: 32'h0000_00d1};
        repeat (2) @(posedge clk_i);
        rst_ni <= 1'b1;
        reset_defaults();
        csr_access_rules();
        scalar_lanes();
        priority_and_hold();
        mixed_traffic();
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+source
+incdir+sim
source/mem_bus_pkg.sv
source/vcsr_pkg.sv
source/vcsr_regs.sv
source/data_port_arbiter.sv
source/mem_port_arbiter.sv
source/mem_subsys_top.sv
sim/tb_mem_subsys.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     := --binary --timing -j 0 -Wno-fatal
TOP       := tb_mem_subsys
FILELIST  := sources.f

SRCS := $(wildcard source/*.sv source/*.svh sim/*.sv sim/*.svh) $(FILELIST)
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir
